// File: common/mips_isa_pkg.sv
package mips_isa_pkg;

    // Primary opcodes of the I-type memory instructions
    localparam logic [5:0] opc_lb  = 6'h20;
    localparam logic [5:0] opc_lh  = 6'h21;
    localparam logic [5:0] opc_lwl = 6'h22;
    localparam logic [5:0] opc_lw  = 6'h23;
    localparam logic [5:0] opc_lbu = 6'h24;
    localparam logic [5:0] opc_lhu = 6'h25;
    localparam logic [5:0] opc_lwr = 6'h26;
    localparam logic [5:0] opc_sb  = 6'h28;
    localparam logic [5:0] opc_sh  = 6'h29;
    localparam logic [5:0] opc_sw  = 6'h2b;
    localparam logic [5:0] opc_lui = 6'h0f;

    typedef logic [4:0] reg_idx_t;

    // Memory operation after decode
    typedef enum logic [3:0] {
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_lwl,
        op_lwr,
        op_lui,
        op_sb,
        op_sh,
        op_sw,
        op_bad      // Anything the unit does not handle
    } mem_op_e;

    // I-type layout, opcode in the top bits
    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [15:0] imm;
    } itype_t;

endpackage

// File: common/mem_bus_pkg.sv
package mem_bus_pkg;

    localparam int data_w  = 32;
    localparam int lanes   = data_w / 8;

    typedef logic [data_w-1:0] word_t;
    typedef logic [lanes-1:0]  byte_en_t;
    typedef logic [1:0]        lane_t;      // Byte offset inside a word

    // Same word seen per byte lane or per halfword
    typedef union packed {
        logic [lanes-1:0][7:0]     bytes;
        logic [lanes/2-1:0][15:0]  halves;
    } data_word_u;

endpackage

// File: common/lane_plan_if.sv
interface lane_plan_if;

    mips_isa_pkg::mem_op_e  op;
    mem_bus_pkg::word_t     word_address;   // Low two bits cleared
    mem_bus_pkg::lane_t     lane;
    mem_bus_pkg::byte_en_t  byte_en;
    mips_isa_pkg::reg_idx_t rt;
    logic [15:0]            imm;
    logic                   fault;
    mem_bus_pkg::lane_t     ea_lane;        // Unregistered lane for the store aligner

    modport addr_side (output op, word_address, lane, byte_en, rt, imm, fault, ea_lane);
    modport seq_side (input op, word_address, lane, byte_en, rt, imm, fault);

endinterface

// File: load_store/lsu_addr_unit.sv
module lsu_addr_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 capture,
    input  mips_isa_pkg::itype_t instr,
    input  mem_bus_pkg::word_t   base,
    lane_plan_if.addr_side       plan
);

    mips_isa_pkg::mem_op_e op;
    mem_bus_pkg::word_t    offset;
    mem_bus_pkg::word_t    eff_addr;
    mem_bus_pkg::lane_t    lane;
    mem_bus_pkg::byte_en_t byte_en;
    logic                  fault;

    always_comb begin
        case (instr.opcode)
            mips_isa_pkg::opc_lb:  op = mips_isa_pkg::op_lb;
            mips_isa_pkg::opc_lbu: op = mips_isa_pkg::op_lbu;
            mips_isa_pkg::opc_lh:  op = mips_isa_pkg::op_lh;
            mips_isa_pkg::opc_lhu: op = mips_isa_pkg::op_lhu;
            mips_isa_pkg::opc_lw:  op = mips_isa_pkg::op_lw;
            mips_isa_pkg::opc_lwl: op = mips_isa_pkg::op_lwl;
            mips_isa_pkg::opc_lwr: op = mips_isa_pkg::op_lwr;
            mips_isa_pkg::opc_lui: op = mips_isa_pkg::op_lui;
            mips_isa_pkg::opc_sb:  op = mips_isa_pkg::op_sb;
            mips_isa_pkg::opc_sh:  op = mips_isa_pkg::op_sh;
            mips_isa_pkg::opc_sw:  op = mips_isa_pkg::op_sw;
            default:               op = mips_isa_pkg::op_bad;
        endcase
    end

    assign offset       = {{16{instr.imm[15]}}, instr.imm};
    assign eff_addr     = base + offset;
    assign lane         = eff_addr[1:0];
    assign plan.ea_lane = lane;

    // Lane plan and alignment check
    always_comb begin
        byte_en = '0;
        fault   = 1'b0;
        case (op)
            mips_isa_pkg::op_lb, mips_isa_pkg::op_lbu, mips_isa_pkg::op_sb: begin
                byte_en = 4'b0001 << lane;
            end
            mips_isa_pkg::op_lh, mips_isa_pkg::op_lhu, mips_isa_pkg::op_sh: begin
                byte_en = lane[1] ? 4'b1100 : 4'b0011;
                fault   = lane[0];                  // Odd address
            end
            mips_isa_pkg::op_lw, mips_isa_pkg::op_sw: begin
                byte_en = 4'b1111;
                fault   = (lane != 2'd0);
            end
            mips_isa_pkg::op_lwl: byte_en = 4'b1111 >> ~lane;  // Lanes 0 to k
            mips_isa_pkg::op_lwr: byte_en = 4'b1111 << lane;   // Lanes k to 3
            mips_isa_pkg::op_lui: byte_en = '0;                // No bus access
            default:              fault   = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            plan.op    <= mips_isa_pkg::op_bad;
            plan.fault <= 1'b0;
        end else if (capture) begin
            plan.op    <= op;
            plan.fault <= fault;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            plan.word_address <= {eff_addr[31:2], 2'b00};
            plan.lane         <= lane;
            plan.byte_en      <= byte_en;
            plan.rt           <= instr.rt;
            plan.imm          <= instr.imm;
        end
    end

    // Any accepted memory access that survives the checks must touch a lane
    a_plan_has_lanes: assert property (@(posedge clk) disable iff (!rst_n)
        capture |=> plan.fault || plan.op == mips_isa_pkg::op_lui || plan.byte_en != '0);

endmodule

// File: load_store/lsu_store_align.sv
module lsu_store_align (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     capture,
    input  mips_isa_pkg::itype_t     instr,
    input  mem_bus_pkg::word_t       rt_data,
    input  mem_bus_pkg::lane_t       lane,
    output mem_bus_pkg::data_word_u  st_data,
    output mem_bus_pkg::word_t       rt_old
);

    mem_bus_pkg::data_word_u placed;

    always_comb begin
        placed = '0;
        case (instr.opcode)
            mips_isa_pkg::opc_sb: placed.bytes[lane]      = rt_data[7:0];
            mips_isa_pkg::opc_sh: placed.halves[lane[1]]  = rt_data[15:0];
            default:              placed                  = rt_data;  // sw as is
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st_data <= '0;
            rt_old  <= '0;
        end else if (capture) begin
            st_data <= placed;
            rt_old  <= rt_data;     // Kept for lwl/lwr merge
        end
    end

endmodule

// File: load_store/lsu_load_extract.sv
module lsu_load_extract (
    input  mips_isa_pkg::mem_op_e    op,
    input  mem_bus_pkg::lane_t       lane,
    input  logic [15:0]              imm,
    input  mem_bus_pkg::data_word_u  rd_data,
    input  mem_bus_pkg::word_t       rt_old,
    output mem_bus_pkg::word_t       result
);

    logic [7:0]         sel_byte;
    logic [15:0]        sel_half;
    logic [4:0]         left_amt;
    logic [4:0]         right_amt;
    mem_bus_pkg::word_t rd_word;

    assign sel_byte  = rd_data.bytes[lane];
    assign sel_half  = rd_data.halves[lane[1]];
    assign rd_word   = rd_data;
    assign left_amt  = {~lane, 3'b000};    // 8 * (3 - k)
    assign right_amt = {lane, 3'b000};     // 8 * k

    always_comb begin
        case (op)
            mips_isa_pkg::op_lb: begin
                result = {{24{sel_byte[7]}}, sel_byte};
            end
            mips_isa_pkg::op_lbu: begin
                result = {24'h000000, sel_byte};
            end
            mips_isa_pkg::op_lh: begin
                result = {{16{sel_half[15]}}, sel_half};
            end
            mips_isa_pkg::op_lhu: begin
                result = {16'h0000, sel_half};
            end
            mips_isa_pkg::op_lw: begin
                result = rd_word;
            end
            mips_isa_pkg::op_lwl: begin
                // Low 3-k bytes come from old rt
                result = (rd_word << left_amt) | (rt_old & ~(32'hffff_ffff << left_amt));
            end
            mips_isa_pkg::op_lwr: begin
                // Top k bytes come from old rt
                result = (rd_word >> right_amt) | (rt_old & ~(32'hffff_ffff >> right_amt));
            end
            mips_isa_pkg::op_lui: begin
                result = {imm, 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: load_store/lsu_sequencer.sv
module lsu_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    output logic                    capture,
    lane_plan_if.seq_side           plan,
    input  mem_bus_pkg::data_word_u st_data,
    input  mem_bus_pkg::word_t      rt_old,
    output mem_bus_pkg::word_t      mem_address,
    output mem_bus_pkg::byte_en_t   mem_byteenable,
    output mem_bus_pkg::word_t      mem_writedata,
    output logic                    mem_write,
    output logic                    mem_read,
    input  mem_bus_pkg::word_t      mem_readdata,
    input  logic                    mem_waitrequest,
    output logic                    resp_valid,
    input  logic                    resp_ready,
    output logic                    resp_reg_write,
    output mips_isa_pkg::reg_idx_t  resp_reg,
    output mem_bus_pkg::word_t      resp_data,
    output logic                    resp_fault
);

    typedef enum logic [1:0] {st_idle, st_bus, st_resp} state_e;

    state_e                  state;
    logic                    is_load;
    logic                    is_store;
    logic                    skip_bus;
    logic                    bus_done;
    mem_bus_pkg::data_word_u rd_u;
    mem_bus_pkg::word_t      ext_result;
    mem_bus_pkg::word_t      result_q;

    assign is_load  = plan.op inside {mips_isa_pkg::op_lb, mips_isa_pkg::op_lbu,
                                      mips_isa_pkg::op_lh, mips_isa_pkg::op_lhu,
                                      mips_isa_pkg::op_lw, mips_isa_pkg::op_lwl,
                                      mips_isa_pkg::op_lwr};
    assign is_store = plan.op inside {mips_isa_pkg::op_sb, mips_isa_pkg::op_sh,
                                      mips_isa_pkg::op_sw};
    assign skip_bus = plan.fault || !(is_load || is_store);  // lui or fault

    assign req_ready = (state == st_idle);
    assign capture   = req_valid && req_ready;

    // Bus fields come straight from the captured plan, stable until next capture
    assign mem_address    = plan.word_address;
    assign mem_byteenable = plan.byte_en;
    assign mem_writedata  = st_data;
    assign mem_read       = (state == st_bus) && !skip_bus && is_load;
    assign mem_write      = (state == st_bus) && !skip_bus && is_store;
    assign bus_done       = (mem_read || mem_write) && !mem_waitrequest;

    assign rd_u = mem_readdata;

    lsu_load_extract u_extract (
        .op      (plan.op),
        .lane    (plan.lane),
        .imm     (plan.imm),
        .rd_data (rd_u),
        .rt_old  (rt_old),
        .result  (ext_result)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (capture) state <= st_bus;
                end
                st_bus: begin
                    if (skip_bus) begin
                        if (resp_ready) state <= st_idle;   // Answered in place
                    end else if (bus_done) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    if (resp_ready) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Read data is only valid on the completing edge
    always_ff @(posedge clk) begin
        if (bus_done) begin
            result_q <= is_load ? ext_result : '0;
        end
    end

    assign resp_valid     = (state == st_resp) || (state == st_bus && skip_bus);
    assign resp_data      = (state == st_resp) ? result_q : (plan.fault ? '0 : ext_result);
    assign resp_reg_write = resp_valid && !plan.fault
                            && (is_load || plan.op == mips_isa_pkg::op_lui);
    assign resp_reg       = plan.rt;
    assign resp_fault     = resp_valid && plan.fault;

    a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write));

    // Avalon hold rule under waitrequest
    a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_read || mem_write) && mem_waitrequest |=>
            $stable(mem_address) && $stable(mem_byteenable) && $stable(mem_writedata)
            && $stable(mem_read) && $stable(mem_write));

    a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        !(req_ready && resp_valid));

endmodule

// File: source/load_store_unit.sv
module load_store_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  mem_bus_pkg::word_t     req_instr,
    input  mem_bus_pkg::word_t     req_base,
    input  mem_bus_pkg::word_t     req_rt_data,
    output mem_bus_pkg::word_t     mem_address,
    output mem_bus_pkg::byte_en_t  mem_byteenable,
    output mem_bus_pkg::word_t     mem_writedata,
    output logic                   mem_write,
    output logic                   mem_read,
    input  mem_bus_pkg::word_t     mem_readdata,
    input  logic                   mem_waitrequest,
    output logic                   resp_valid,
    input  logic                   resp_ready,
    output logic                   resp_reg_write,
    output mips_isa_pkg::reg_idx_t resp_reg,
    output mem_bus_pkg::word_t     resp_data,
    output logic                   resp_fault
);

    logic                    capture;
    mem_bus_pkg::data_word_u st_data;
    mem_bus_pkg::word_t      rt_old;

    lane_plan_if plan ();

    lsu_addr_unit u_addr (
        .clk     (clk),
        .rst_n   (rst_n),
        .capture (capture),
        .instr   (req_instr),
        .base    (req_base),
        .plan    (plan.addr_side)
    );

    lsu_store_align u_store (
        .clk     (clk),
        .rst_n   (rst_n),
        .capture (capture),
        .instr   (req_instr),
        .rt_data (req_rt_data),
        .lane    (plan.ea_lane),
        .st_data (st_data),
        .rt_old  (rt_old)
    );

    lsu_sequencer u_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .capture         (capture),
        .plan            (plan.seq_side),
        .st_data         (st_data),
        .rt_old          (rt_old),
        .mem_address     (mem_address),
        .mem_byteenable  (mem_byteenable),
        .mem_writedata   (mem_writedata),
        .mem_write       (mem_write),
        .mem_read        (mem_read),
        .mem_readdata    (mem_readdata),
        .mem_waitrequest (mem_waitrequest),
        .resp_valid      (resp_valid),
        .resp_ready      (resp_ready),
        .resp_reg_write  (resp_reg_write),
        .resp_reg        (resp_reg),
        .resp_data       (resp_data),
        .resp_fault      (resp_fault)
    );

endmodule

// File: testbench/load_store_unit_tb.sv
module load_store_unit_tb;

    localparam int mem_bytes      = 1024;
    localparam int cycles_per_req = 40;

    // Opcodes for the random mix, the top entry is not a memory op
    localparam logic [11:0][5:0] mix_ops = {
        6'h3f, mips_isa_pkg::opc_lui, mips_isa_pkg::opc_sw, mips_isa_pkg::opc_sh,
        mips_isa_pkg::opc_sb, mips_isa_pkg::opc_lwr, mips_isa_pkg::opc_lwl,
        mips_isa_pkg::opc_lw, mips_isa_pkg::opc_lhu, mips_isa_pkg::opc_lh,
        mips_isa_pkg::opc_lbu, mips_isa_pkg::opc_lb
    };

    typedef struct packed {
        logic                   bus;
        logic                   write;
        mem_bus_pkg::word_t     addr;
        mem_bus_pkg::byte_en_t  en;
        mem_bus_pkg::word_t     wdata;
        logic                   fault;
        logic                   reg_write;
        mips_isa_pkg::reg_idx_t reg_idx;
        mem_bus_pkg::word_t     data;
    } expect_t;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   req_valid;
    logic                   req_ready;
    mem_bus_pkg::word_t     req_instr;
    mem_bus_pkg::word_t     req_base;
    mem_bus_pkg::word_t     req_rt_data;
    mem_bus_pkg::word_t     mem_address;
    mem_bus_pkg::byte_en_t  mem_byteenable;
    mem_bus_pkg::word_t     mem_writedata;
    logic                   mem_write;
    logic                   mem_read;
    mem_bus_pkg::word_t     mem_readdata;
    logic                   mem_waitrequest;
    logic                   resp_valid;
    logic                   resp_ready;
    logic                   resp_reg_write;
    mips_isa_pkg::reg_idx_t resp_reg;
    mem_bus_pkg::word_t     resp_data;
    logic                   resp_fault;

    integer     seed;
    logic [7:0] mem [mem_bytes];       // Written by the DUT through the bus
    logic [7:0] shadow [mem_bytes];    // Reference copy, written from expected stores

    string                q_name[$];
    mips_isa_pkg::itype_t q_instr[$];
    mem_bus_pkg::word_t   q_base[$];
    mem_bus_pkg::word_t   q_rt[$];

    expect_t cur_exp;
    string   cur_name;
    int      n_issued;
    int      n_taken = 0;
    logic    bus_seen = 1'b0;
    int      cycles = 0;
    int      cycle_limit;

    load_store_unit DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_instr       (req_instr),
        .req_base        (req_base),
        .req_rt_data     (req_rt_data),
        .mem_address     (mem_address),
        .mem_byteenable  (mem_byteenable),
        .mem_writedata   (mem_writedata),
        .mem_write       (mem_write),
        .mem_read        (mem_read),
        .mem_readdata    (mem_readdata),
        .mem_waitrequest (mem_waitrequest),
        .resp_valid      (resp_valid),
        .resp_ready      (resp_ready),
        .resp_reg_write  (resp_reg_write),
        .resp_reg        (resp_reg),
        .resp_data       (resp_data),
        .resp_fault      (resp_fault)
    );

    always #2 clk = ~clk;

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_failure(string msg);
        $display("Failure: %s", msg);
        stop_run();
    endtask

    task automatic check_word(string name, mem_bus_pkg::word_t exp, mem_bus_pkg::word_t act);
        if (exp !== act) begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_en(string name, mem_bus_pkg::byte_en_t exp,
                            mem_bus_pkg::byte_en_t act);
        if (exp !== act) begin
            $display("** Error: %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("** Error: %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // Fill value mixes all ten index bits
    function automatic logic [7:0] fill_byte(logic [9:0] idx);
        return idx[7:0] ^ {idx[9:8], idx[9:4]} ^ 8'h5a;
    endfunction

    function automatic mem_bus_pkg::word_t shadow_word(mem_bus_pkg::word_t addr);
        logic [9:0] i;
        i = {addr[9:2], 2'b00};
        return {shadow[i + 3], shadow[i + 2], shadow[i + 1], shadow[i]};
    endfunction

    function automatic mem_bus_pkg::word_t lane_mask(mem_bus_pkg::byte_en_t en);
        mem_bus_pkg::word_t m;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{en[i]}};
        end
        return m;
    endfunction

    // Expected bus transfer and response from the lane rules
    function automatic expect_t reference(mips_isa_pkg::itype_t ins, mem_bus_pkg::word_t base,
                                          mem_bus_pkg::word_t rt);
        expect_t            e;
        mem_bus_pkg::word_t ea;
        mem_bus_pkg::word_t w;
        int                 k;
        int                 s;
        logic [7:0]         b;
        logic [15:0]        h;
        e         = '0;
        ea        = base + {{16{ins.imm[15]}}, ins.imm};
        k         = ea[1:0];
        s         = 3 - k;
        w         = shadow_word(ea);
        b         = w[8*k +: 8];
        h         = w[16*(k/2) +: 16];
        e.addr    = {ea[31:2], 2'b00};
        e.reg_idx = ins.rt;
        e.bus     = 1'b1;
        case (ins.opcode)
            mips_isa_pkg::opc_lb, mips_isa_pkg::opc_lbu, mips_isa_pkg::opc_sb: begin
                e.en[k] = 1'b1;
            end
            mips_isa_pkg::opc_lh, mips_isa_pkg::opc_lhu, mips_isa_pkg::opc_sh: begin
                e.en[2*(k/2)]     = 1'b1;
                e.en[2*(k/2) + 1] = 1'b1;
                e.fault           = ea[0];      // Odd address
            end
            mips_isa_pkg::opc_lw, mips_isa_pkg::opc_sw: begin
                e.en    = 4'hf;
                e.fault = (k != 0);
            end
            mips_isa_pkg::opc_lwl, mips_isa_pkg::opc_lwr: begin
                for (int i = 0; i < 4; i++) begin
                    e.en[i] = (ins.opcode == mips_isa_pkg::opc_lwl) ? (i <= k) : (i >= k);
                end
            end
            mips_isa_pkg::opc_lui: e.bus = 1'b0;
            default:               e.fault = 1'b1;
        endcase
        case (ins.opcode)
            mips_isa_pkg::opc_lb:  e.data = {{24{b[7]}}, b};
            mips_isa_pkg::opc_lbu: e.data = {24'h000000, b};
            mips_isa_pkg::opc_lh:  e.data = {{16{h[15]}}, h};
            mips_isa_pkg::opc_lhu: e.data = {16'h0000, h};
            mips_isa_pkg::opc_lw:  e.data = w;
            mips_isa_pkg::opc_lwl: begin
                for (int i = 0; i < 4; i++) begin
                    e.data[8*i +: 8] = (i < s) ? rt[8*i +: 8] : w[8*(i - s) +: 8];
                end
            end
            mips_isa_pkg::opc_lwr: begin
                for (int i = 0; i < 4; i++) begin
                    e.data[8*i +: 8] = (i >= 4 - k) ? rt[8*i +: 8] : w[8*(i + k) +: 8];
                end
            end
            mips_isa_pkg::opc_lui: e.data = {ins.imm, 16'h0000};
            mips_isa_pkg::opc_sb:  e.wdata = {4{rt[7:0]}};
            mips_isa_pkg::opc_sh:  e.wdata = {2{rt[15:0]}};
            mips_isa_pkg::opc_sw:  e.wdata = rt;
            default:               e.data = '0;
        endcase
        e.write = ins.opcode inside {mips_isa_pkg::opc_sb, mips_isa_pkg::opc_sh,
                                     mips_isa_pkg::opc_sw};
        e.reg_write = !e.fault && !e.write;
        if (e.fault) begin
            e.bus  = 1'b0;
            e.data = '0;
        end
        return e;
    endfunction

    task automatic apply_store(expect_t e);
        if (e.bus && e.write) begin
            for (int i = 0; i < 4; i++) begin
                if (e.en[i]) shadow[e.addr[9:0] + i] = e.wdata[8*i +: 8];
            end
        end
    endtask

    // Queue one request whose effective address is ea
    task automatic add_req(string name, logic [5:0] opc, mem_bus_pkg::word_t ea,
                           logic [15:0] imm, mem_bus_pkg::word_t rt_val);
        mips_isa_pkg::itype_t ins;
        ins.opcode = opc;
        ins.rs     = $random(seed);
        ins.rt     = $random(seed);
        ins.imm    = imm;
        q_name.push_back(name);
        q_instr.push_back(ins);
        q_base.push_back(ea - {{16{imm[15]}}, imm});
        q_rt.push_back(rt_val);
    endtask

    task automatic build_tests();
        mem_bus_pkg::word_t ea;
        mem_bus_pkg::word_t val;
        logic [15:0]        imm;
        for (int i = 0; i < 6; i++) begin
            ea      = $random(seed);
            ea[1:0] = 2'b00;
            imm     = $random(seed);
            imm[15] = i[0];                 // Negative offset every other pair
            val     = $random(seed);
            add_req($sformatf("sw pair %0d", i), mips_isa_pkg::opc_sw, ea, imm, val);
            add_req($sformatf("lw pair %0d", i), mips_isa_pkg::opc_lw, ea, $random(seed),
                    $random(seed));
        end
        for (int j = 0; j < 2; j++) begin
            ea      = $random(seed);
            ea[1:0] = 2'b00;
            val     = (j == 0) ? 32'h7f80c31a : $random(seed);  // Mixed sign bits
            add_req("sw before subword", mips_isa_pkg::opc_sw, ea, $random(seed), val);
            for (int k = 0; k < 4; k++) begin
                add_req($sformatf("lb lane %0d", k), mips_isa_pkg::opc_lb, ea + k,
                        $random(seed), $random(seed));
                add_req($sformatf("lbu lane %0d", k), mips_isa_pkg::opc_lbu, ea + k,
                        $random(seed), $random(seed));
                if (k % 2 == 0) begin
                    add_req($sformatf("lh lane %0d", k), mips_isa_pkg::opc_lh, ea + k,
                            $random(seed), $random(seed));
                    add_req($sformatf("lhu lane %0d", k), mips_isa_pkg::opc_lhu, ea + k,
                            $random(seed), $random(seed));
                end
            end
        end
        ea      = $random(seed);
        ea[1:0] = 2'b00;
        for (int k = 0; k < 4; k++) begin
            add_req($sformatf("sb lane %0d", k), mips_isa_pkg::opc_sb, ea + k,
                    $random(seed), $random(seed));
            add_req("lw after sb", mips_isa_pkg::opc_lw, ea, $random(seed), $random(seed));
            if (k % 2 == 0) begin
                add_req($sformatf("sh lane %0d", k), mips_isa_pkg::opc_sh, ea + k,
                        $random(seed), $random(seed));
                add_req("lw after sh", mips_isa_pkg::opc_lw, ea, $random(seed), $random(seed));
            end
            add_req($sformatf("lwl lane %0d", k), mips_isa_pkg::opc_lwl, ea + k,
                    $random(seed), $random(seed));
            add_req($sformatf("lwr lane %0d", k), mips_isa_pkg::opc_lwr, ea + k,
                    $random(seed), $random(seed));
        end
        add_req("lui a", mips_isa_pkg::opc_lui, $random(seed), 16'h8001, $random(seed));
        add_req("lui b", mips_isa_pkg::opc_lui, $random(seed), $random(seed), $random(seed));
        for (int k = 1; k < 4; k++) begin
            add_req("misaligned lw", mips_isa_pkg::opc_lw, ea + k, $random(seed), 0);
            add_req("misaligned sw", mips_isa_pkg::opc_sw, ea + k, $random(seed), 0);
            if (k % 2 == 1) begin
                add_req("misaligned lh", mips_isa_pkg::opc_lh, ea + k, $random(seed), 0);
                add_req("misaligned lhu", mips_isa_pkg::opc_lhu, ea + k, $random(seed), 0);
                add_req("misaligned sh", mips_isa_pkg::opc_sh, ea + k, $random(seed), 0);
            end
        end
        add_req("bad opcode 00", 6'h00, ea, $random(seed), 0);
        add_req("bad opcode 2a", 6'h2a, ea, $random(seed), 0);
        for (int i = 0; i < 40; i++) begin
            add_req($sformatf("mix %0d", i), mix_ops[$unsigned($random(seed)) % 12],
                    $random(seed), $random(seed), $random(seed));
        end
    endtask

    // Bus slave, the first cycle of each transfer always waits
    always @(posedge clk) begin : bus_model
        logic [9:0] a;
        a = {mem_address[9:2], 2'b00};
        if (!rst_n) begin
            mem_waitrequest <= 1'b1;
            resp_ready      <= 1'b0;
        end else begin
            resp_ready <= ($random(seed) & 3) != 0;
            if ((mem_read || mem_write) && !mem_waitrequest) begin
                for (int i = 0; i < 4; i++) begin
                    if (mem_write && mem_byteenable[i]) mem[a + i] <= mem_writedata[8*i +: 8];
                end
                mem_waitrequest <= 1'b1;
            end else if (mem_read || mem_write) begin
                mem_readdata    <= {mem[a + 3], mem[a + 2], mem[a + 1], mem[a]};
                mem_waitrequest <= $random(seed) & 1;   // Random stall
            end else begin
                mem_waitrequest <= 1'b1;
            end
        end
    end

    // Compares bus activity and responses against the current expectation
    always @(posedge clk) begin
        if (rst_n) begin
            if (n_issued != n_taken && req_ready) begin
                report_failure({cur_name, ": req_ready rose before the response was taken"});
            end
            if (mem_read || mem_write) begin
                if (n_issued == n_taken || !cur_exp.bus) begin
                    report_failure({cur_name, ": bus access where none is allowed"});
                end
                check_flag({cur_name, " mem_write"}, cur_exp.write, mem_write);
                check_flag({cur_name, " mem_read"}, !cur_exp.write, mem_read);
                check_word({cur_name, " mem_address"}, cur_exp.addr, mem_address);
                check_en({cur_name, " mem_byteenable"}, cur_exp.en, mem_byteenable);
                if (cur_exp.write) begin
                    check_word({cur_name, " mem_writedata"}, cur_exp.wdata & lane_mask(cur_exp.en),
                               mem_writedata & lane_mask(cur_exp.en));
                end
                if (!mem_waitrequest) begin
                    if (bus_seen) report_failure({cur_name, ": second bus transfer"});
                    bus_seen <= 1'b1;
                end
            end
            if (resp_valid) begin
                if (n_issued == n_taken) report_failure("Response with no request outstanding");
                check_flag({cur_name, " resp_fault"}, cur_exp.fault, resp_fault);
                check_flag({cur_name, " resp_reg_write"}, cur_exp.reg_write, resp_reg_write);
                check_word({cur_name, " resp_reg"}, {27'd0, cur_exp.reg_idx}, {27'd0, resp_reg});
                if (cur_exp.reg_write) check_word({cur_name, " resp_data"}, cur_exp.data, resp_data);
                if (resp_ready) begin
                    if (cur_exp.bus && !bus_seen) begin
                        report_failure({cur_name, ": response came without its bus transfer"});
                    end
                    n_taken  <= n_taken + 1;
                    bus_seen <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) report_failure("Run exceeded its cycle limit, response missing");
    end

    initial begin
        expect_t want;
        seed            = 32'h04fdf995;
        rst_n           = 1'b0;
        req_valid       = 1'b0;
        req_instr       = '0;
        req_base        = '0;
        req_rt_data     = '0;
        mem_readdata    = '0;
        mem_waitrequest = 1'b1;
        resp_ready      = 1'b0;
        n_issued        = 0;
        cur_exp         = '0;
        cur_name        = "idle";
        for (int i = 0; i < mem_bytes; i++) begin
            mem[i]    = fill_byte(i[9:0]);
            shadow[i] = fill_byte(i[9:0]);
        end
        build_tests();
        cycle_limit = cycles_per_req * q_instr.size() + 8;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_flag("after reset req_ready", 1'b1, req_ready);
        check_flag("after reset resp_valid", 1'b0, resp_valid);
        check_flag("after reset mem_read", 1'b0, mem_read);
        check_flag("after reset mem_write", 1'b0, mem_write);

        // Next request is presented as soon as the previous one is taken
        for (int i = 0; i < q_instr.size(); i++) begin
            req_valid   <= 1'b1;
            req_instr   <= q_instr[i];
            req_base    <= q_base[i];
            req_rt_data <= q_rt[i];
            do @(posedge clk); while (!req_ready);
            want = reference(q_instr[i], q_base[i], q_rt[i]);
            apply_store(want);
            cur_exp  <= want;
            cur_name <= q_name[i];
            n_issued <= n_issued + 1;
        end
        req_valid <= 1'b0;
        while (n_taken != q_instr.size()) @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: sim.f
common/mips_isa_pkg.sv
common/mem_bus_pkg.sv
common/lane_plan_if.sv
load_store/lsu_addr_unit.sv
load_store/lsu_store_align.sv
load_store/lsu_load_extract.sv
load_store/lsu_sequencer.sv
source/load_store_unit.sv
testbench/load_store_unit_tb.sv
